//--- logic/eeprom_ctrl_top.sv
`timescale 1ns/1ns

module eeprom_ctrl_top
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  eeprom_pkg::eeprom_req_t req,
    input  logic                    req_valid,
    output logic                    busy,
    output logic                    done,
    output eeprom_pkg::eeprom_rsp_t rsp,
    output logic                    scl,
    output logic                    sda_oe,   // high pulls sda low
    input  logic                    sda_in
);

    eeprom_pkg::bus_cmd_t cmd;
    eeprom_pkg::bus_res_t res;
    logic                 cmd_valid;
    logic                 cmd_ready;
    logic                 res_valid;

    eeprom_sequencer u_seq
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .req       (req),
        .req_valid (req_valid),
        .busy      (busy),
        .done      (done),
        .rsp       (rsp),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .res       (res),
        .res_valid (res_valid)
    );

    i2c_bit_engine u_bit
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .res       (res),
        .res_valid (res_valid),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda_in    (sda_in)
    );

endmodule

//--- logic/eeprom_defs.svh
`ifndef EEPROM_DEFS_SVH
`define EEPROM_DEFS_SVH

// CLK cycles per quarter of an SCL period
`define EE_QTR_CLKS 2

// device type code in the control byte
`define EE_DEV_CODE 4'b1010

`define EE_ADDR_W 11

`define EE_MEM_INIT 8'hFF  // erased byte

`endif

//--- logic/eeprom_pkg.sv
`include "eeprom_defs.svh"

package eeprom_pkg;

    typedef enum logic {EE_WRITE = 1'b0, EE_READ = 1'b1} ee_op_e;

    typedef struct packed {
        ee_op_e                op;
        logic [`EE_ADDR_W-1:0] addr;
        logic [7:0]            wdata;
    } eeprom_req_t;

    typedef struct packed {
        logic [7:0] rdata;
        logic       nack;
    } eeprom_rsp_t;

    typedef enum logic [1:0] {BUS_START, BUS_STOP, BUS_TX, BUS_RX} bus_op_e;

    typedef struct packed {
        bus_op_e    op;
        logic [7:0] tx_byte;
        logic       master_ack;  // sda level in the ninth bit of BUS_RX, 0 acks
    } bus_cmd_t;

    typedef struct packed {
        logic [7:0] rx_byte;
        logic       slave_nack;
    } bus_res_t;

    typedef enum logic [3:0] {SQ_IDLE, SQ_START, SQ_CTRL_W, SQ_ADDR, SQ_DATA,
                              SQ_RESTART, SQ_CTRL_R, SQ_READ, SQ_STOP, SQ_DONE} seq_state_e;

    typedef enum logic [2:0] {BE_IDLE, BE_START, BE_SHIFT, BE_ACK, BE_STOP} bit_state_e;

endpackage

//--- logic/eeprom_sequencer.sv
`timescale 1ns/1ns
`include "eeprom_defs.svh"

module eeprom_sequencer
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  eeprom_pkg::eeprom_req_t req,
    input  logic                    req_valid,
    output logic                    busy,
    output logic                    done,
    output eeprom_pkg::eeprom_rsp_t rsp,
    output eeprom_pkg::bus_cmd_t    cmd,
    output logic                    cmd_valid,
    input  logic                    cmd_ready,
    input  eeprom_pkg::bus_res_t    res,
    input  logic                    res_valid
);

    eeprom_pkg::seq_state_e  state;
    eeprom_pkg::seq_state_e  nxt;
    eeprom_pkg::eeprom_req_t req_q;
    logic [7:0]              rdata_q;
    logic                    nack_q;
    logic                    take;
    logic                    tx_nack;

    assign take    = req_valid && !busy;
    assign tx_nack = (cmd.op == eeprom_pkg::BUS_TX) && res.slave_nack;

    // bus command of the current step
    always_comb
    begin
        cmd            = '0;
        cmd.master_ack = 1'b1;  // single byte read ends with nack
        case (state)
            eeprom_pkg::SQ_CTRL_W:
            begin
                cmd.op      = eeprom_pkg::BUS_TX;
                cmd.tx_byte = {`EE_DEV_CODE, req_q.addr[`EE_ADDR_W-1:8], 1'b0};
            end
            eeprom_pkg::SQ_ADDR:
            begin
                cmd.op      = eeprom_pkg::BUS_TX;
                cmd.tx_byte = req_q.addr[7:0];
            end
            eeprom_pkg::SQ_DATA:
            begin
                cmd.op      = eeprom_pkg::BUS_TX;
                cmd.tx_byte = req_q.wdata;
            end
            eeprom_pkg::SQ_CTRL_R:
            begin
                cmd.op      = eeprom_pkg::BUS_TX;
                cmd.tx_byte = {`EE_DEV_CODE, req_q.addr[`EE_ADDR_W-1:8], 1'b1};
            end
            eeprom_pkg::SQ_READ: cmd.op = eeprom_pkg::BUS_RX;
            eeprom_pkg::SQ_STOP: cmd.op = eeprom_pkg::BUS_STOP;
            default:             cmd.op = eeprom_pkg::BUS_START;
        endcase
    end

    always_comb
    begin
        case (state)
            eeprom_pkg::SQ_START:   nxt = eeprom_pkg::SQ_CTRL_W;
            eeprom_pkg::SQ_CTRL_W:  nxt = tx_nack ? eeprom_pkg::SQ_STOP : eeprom_pkg::SQ_ADDR;
            eeprom_pkg::SQ_ADDR:
                if (tx_nack)
                    nxt = eeprom_pkg::SQ_STOP;
                else if (req_q.op == eeprom_pkg::EE_READ)
                    nxt = eeprom_pkg::SQ_RESTART;
                else
                    nxt = eeprom_pkg::SQ_DATA;
            eeprom_pkg::SQ_DATA:    nxt = eeprom_pkg::SQ_STOP;
            eeprom_pkg::SQ_RESTART: nxt = eeprom_pkg::SQ_CTRL_R;
            eeprom_pkg::SQ_CTRL_R:  nxt = tx_nack ? eeprom_pkg::SQ_STOP : eeprom_pkg::SQ_READ;
            eeprom_pkg::SQ_READ:    nxt = eeprom_pkg::SQ_STOP;
            eeprom_pkg::SQ_STOP:    nxt = eeprom_pkg::SQ_DONE;
            default:                nxt = eeprom_pkg::SQ_IDLE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= eeprom_pkg::SQ_IDLE;
            busy      <= 1'b0;
            done      <= 1'b0;
            cmd_valid <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (cmd_valid && cmd_ready)
                cmd_valid <= 1'b0;
            if (state == eeprom_pkg::SQ_IDLE)
            begin
                if (take)
                begin
                    busy      <= 1'b1;
                    state     <= eeprom_pkg::SQ_START;
                    cmd_valid <= 1'b1;
                end
            end
            else if (state == eeprom_pkg::SQ_DONE)
            begin
                busy  <= 1'b0;
                done  <= 1'b1;
                state <= eeprom_pkg::SQ_IDLE;
            end
            else if (res_valid)
            begin
                state     <= nxt;
                cmd_valid <= (nxt != eeprom_pkg::SQ_DONE);  // one command outstanding
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (take)
        begin
            req_q   <= req;
            rdata_q <= '0;
            nack_q  <= 1'b0;
        end
        else if (res_valid)
        begin
            if (state == eeprom_pkg::SQ_READ)
                rdata_q <= res.rx_byte;
            else if (tx_nack)
                nack_q <= 1'b1;
        end
        // rsp holds between done pulses
        if (state == eeprom_pkg::SQ_DONE)
        begin
            rsp.rdata <= nack_q ? 8'h00 : rdata_q;
            rsp.nack  <= nack_q;
        end
    end

endmodule

//--- logic/i2c_bit_engine.sv
`timescale 1ns/1ns
`include "eeprom_defs.svh"

module i2c_bit_engine
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  eeprom_pkg::bus_cmd_t cmd,
    input  logic                 cmd_valid,
    output logic                 cmd_ready,
    output eeprom_pkg::bus_res_t res,
    output logic                 res_valid,
    output logic                 scl,
    output logic                 sda_oe,
    input  logic                 sda_in
);

    localparam int QW = $clog2(`EE_QTR_CLKS + 1);

    eeprom_pkg::bit_state_e state;
    eeprom_pkg::bus_op_e    op;
    logic [QW-1:0]          qcnt;
    logic [1:0]             qtr;      // quarter of the current bit
    logic [2:0]             bit_cnt;
    logic [7:0]             shreg;
    logic                   mack;

    logic accept;
    logic qtr_end;
    logic in_bit;
    logic sample;
    logic bit_end;

    assign cmd_ready = (state == eeprom_pkg::BE_IDLE) && !res_valid;
    assign accept    = cmd_valid && cmd_ready;
    assign qtr_end   = (qcnt == QW'(`EE_QTR_CLKS - 1));
    assign in_bit    = (state == eeprom_pkg::BE_SHIFT) || (state == eeprom_pkg::BE_ACK);
    assign sample    = in_bit && qtr_end && (qtr == 2'd1);  // middle of scl high
    assign bit_end   = in_bit && qtr_end && (qtr == 2'd3);

    // quarter sequencing, the outputs of the next quarter are set at each boundary
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= eeprom_pkg::BE_IDLE;
            qcnt      <= '0;
            qtr       <= '0;
            bit_cnt   <= '0;
            scl       <= 1'b1;
            sda_oe    <= 1'b0;
            res_valid <= 1'b0;
        end
        else
        begin
            res_valid <= 1'b0;
            if (state == eeprom_pkg::BE_IDLE)
            begin
                qcnt    <= '0;
                qtr     <= '0;
                bit_cnt <= '0;
                if (accept)
                begin
                    case (cmd.op)
                        eeprom_pkg::BUS_START:
                        begin
                            state  <= eeprom_pkg::BE_START;
                            sda_oe <= 1'b0;  // scl kept, low for a repeated start
                        end
                        eeprom_pkg::BUS_STOP:
                        begin
                            state  <= eeprom_pkg::BE_STOP;
                            scl    <= 1'b0;
                            sda_oe <= 1'b1;
                        end
                        eeprom_pkg::BUS_TX:
                        begin
                            state  <= eeprom_pkg::BE_SHIFT;
                            scl    <= 1'b0;
                            sda_oe <= ~cmd.tx_byte[7];  // msb first
                        end
                        default:
                        begin
                            state  <= eeprom_pkg::BE_SHIFT;
                            scl    <= 1'b0;
                            sda_oe <= 1'b0;
                        end
                    endcase
                end
            end
            else if (!qtr_end)
                qcnt <= qcnt + 1'b1;
            else
            begin
                qcnt <= '0;
                qtr  <= qtr + 2'd1;
                case (qtr)
                    2'd0:
                        scl <= 1'b1;
                    2'd1:
                    begin
                        if (state == eeprom_pkg::BE_START)
                            sda_oe <= 1'b1;  // sda falls while scl high
                        else if (state == eeprom_pkg::BE_STOP)
                            sda_oe <= 1'b0;  // sda rises while scl high
                    end
                    2'd2:
                        if (state != eeprom_pkg::BE_STOP)
                            scl <= 1'b0;
                    default:
                    begin
                        if (state == eeprom_pkg::BE_SHIFT && bit_cnt != 3'd7)
                        begin
                            bit_cnt <= bit_cnt + 3'd1;
                            sda_oe  <= (op == eeprom_pkg::BUS_TX) ? ~shreg[6] : 1'b0;
                        end
                        else if (state == eeprom_pkg::BE_SHIFT)
                        begin
                            // ninth bit, slave acks a write, master answers a read
                            state  <= eeprom_pkg::BE_ACK;
                            sda_oe <= (op == eeprom_pkg::BUS_TX) ? 1'b0 : ~mack;
                        end
                        else
                        begin
                            state     <= eeprom_pkg::BE_IDLE;
                            res_valid <= 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            op             <= cmd.op;
            mack           <= cmd.master_ack;
            shreg          <= cmd.tx_byte;
            res.slave_nack <= 1'b0;
        end
        else if (sample)
        begin
            if (state == eeprom_pkg::BE_ACK)
                res.slave_nack <= (op == eeprom_pkg::BUS_TX) && sda_in;  // released line
            else if (op == eeprom_pkg::BUS_RX)
                shreg <= {shreg[6:0], sda_in};
        end
        else if (bit_end)
        begin
            if (state == eeprom_pkg::BE_ACK)
                res.rx_byte <= shreg;
            else if (op == eeprom_pkg::BUS_TX)
                shreg <= {shreg[6:0], 1'b0};
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_eeprom -o sim_eeprom > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/sim_eeprom > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status" >> sim.log
    echo "TEST FAILED" >> sim.log
fi
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0

//--- sim/eeprom_checker.sv
`timescale 1ns/1ns

module eeprom_checker
(
    input logic                   CLK,
    input logic                   RESET,
    input eeprom_pkg::bit_state_e state,
    input logic                   scl,
    input logic                   sda_oe,
    input logic                   cmd_valid,
    input logic                   cmd_ready,
    input logic                   res_valid
);

    logic cond_edge;  // start or stop in progress
    logic pending;    // command taken and its result not back yet
    int   fail_cnt;

    assign cond_edge = (state == eeprom_pkg::BE_START) || (state == eeprom_pkg::BE_STOP);

    initial
        fail_cnt = 0;

    always_ff @(posedge CLK)
    begin
        if (RESET)
            pending <= 1'b0;
        else if (res_valid)
            pending <= 1'b0;
        else if (cmd_valid && cmd_ready)
            pending <= 1'b1;
    end

    res_pulse: assert property (@(posedge CLK) disable iff (RESET) res_valid |=> !res_valid)
    else
    begin
        $error("res_valid longer than one cycle");
        fail_cnt = fail_cnt + 1;
    end

    sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && !cond_edge) |-> $stable(sda_oe))
    else
    begin
        $error("sda changed while scl high");
        fail_cnt = fail_cnt + 1;
    end

    ready_low: assert property (@(posedge CLK) disable iff (RESET) pending |-> !cmd_ready)
    else
    begin
        $error("cmd_ready high with a result pending");
        fail_cnt = fail_cnt + 1;
    end

endmodule

bind i2c_bit_engine eeprom_checker u_chk
(
    .CLK       (CLK),
    .RESET     (RESET),
    .state     (state),
    .scl       (scl),
    .sda_oe    (sda_oe),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .res_valid (res_valid)
);

//--- sim/eeprom_monitor.sv
`timescale 1ns/1ns

module eeprom_monitor
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    req_valid,
    input  logic                    busy,
    input  logic                    done,
    input  eeprom_pkg::eeprom_rsp_t rsp,
    input  logic [7:0]              exp_data,
    input  logic                    exp_nack,
    input  logic [127:0]            test_name,
    output int                      errors
);

    logic pending;   // an accepted request waits for its done

    initial
    begin
        errors  = 0;
        pending = 1'b0;
    end

    always @(posedge CLK)
    begin
        if (RESET)
            pending = 1'b0;
        else
        begin
            if (pending && !done && !busy)
            begin
                $display("busy low while the request of %0s is in progress", test_name);
                errors = errors + 1;
            end
            if (done)
            begin
                if (!pending)
                begin
                    $display("done pulse without an accepted request in %0s", test_name);
                    errors = errors + 1;
                end
                pending = 1'b0;
                if (rsp.rdata !== exp_data)
                begin
                    $display("FAILED %0s rdata expected %02h actual %02h",
                             test_name, exp_data, rsp.rdata);
                    errors = errors + 1;
                end
                if (rsp.nack !== exp_nack)
                begin
                    $display("FAILED %0s nack expected %0b actual %0b",
                             test_name, exp_nack, rsp.nack);
                    errors = errors + 1;
                end
            end
            if (req_valid && !busy)
            begin
                if (pending)
                begin
                    $display("request accepted before the previous one finished");
                    errors = errors + 1;
                end
                pending = 1'b1;
            end
        end
    end

endmodule

//--- sim/eeprom_slave_model.sv
`timescale 1ns/1ns
`include "eeprom_defs.svh"

module eeprom_slave_model
(
    input  logic scl,
    input  logic sda,
    input  logic nak_mode,   // high: never acknowledge
    output logic sda_pd      // high pulls sda low
);

    logic [7:0]  mem [0:2047];
    logic [7:0]  sh;
    logic [10:0] addr;
    logic [2:0]  page;
    logic        active;
    logic        reading;
    int          bitn;       // bits done in the current byte, -1 right after a start
    int          byten;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = `EE_MEM_INIT;
        sda_pd  = 1'b0;
        active  = 1'b0;
        reading = 1'b0;
        addr    = '0;
        page    = '0;
        bitn    = 0;
        byten   = 0;
    end

    // start or repeated start
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            active  = 1'b1;
            reading = 1'b0;
            bitn    = -1;
            byten   = 0;
            sda_pd  = 1'b0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            active  = 1'b0;  // stop
            reading = 1'b0;
            sda_pd  = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (active && bitn >= 0)
        begin
            if (bitn < 8 && !reading)
                sh = {sh[6:0], sda};
            else if (bitn == 8 && reading && sda === 1'b1)
                active = 1'b0;  // master nack ends the read
        end
    end

    always @(negedge scl)
    begin
        if (active)
        begin
            if (bitn < 0)
                bitn = 0;
            else if (bitn < 7)
            begin
                bitn = bitn + 1;
                if (reading)
                    sda_pd = ~sh[7 - bitn];
            end
            else if (bitn == 7)
            begin
                bitn = 8;
                if (reading)
                    sda_pd = 1'b0;  // master answers
                else
                    take_byte();
            end
            else
            begin
                bitn   = 0;
                sda_pd = 1'b0;
                if (reading)
                begin
                    sh     = mem[addr];
                    addr   = {addr[10:8], addr[7:0] + 8'd1};
                    sda_pd = ~sh[7];
                end
            end
        end
    end

    task automatic take_byte();
        if (byten == 0)
        begin
            if (sh[7:4] == `EE_DEV_CODE && !nak_mode)
            begin
                page   = sh[3:1];
                sda_pd = 1'b1;
                if (sh[0])
                begin
                    reading = 1'b1;
                    addr    = {page, addr[7:0]};
                end
            end
            else
                active = 1'b0;
        end
        else if (byten == 1)
        begin
            addr   = {page, sh};
            sda_pd = 1'b1;
        end
        else
        begin
            mem[addr] = sh;
            addr      = {addr[10:8], addr[7:0] + 8'd1};
            sda_pd    = 1'b1;
        end
        byten = byten + 1;
    endtask

endmodule

//--- sim/eeprom_trace.txt
# name op addr data nak_mode exp_data exp_nack (hex fields)
# op: W write, R read, X random write and read back, B write with req_valid pulsed while busy
wr_basic W 123 A5 0 00 0
rd_basic R 123 00 0 A5 0
wr_page0 W 005 11 0 00 0
wr_page7 W 705 77 0 00 0
rd_page0 R 005 00 0 11 0
rd_page7 R 705 00 0 77 0
rd_erased R 300 00 0 FF 0
wr_nak W 040 3C 1 00 1
rd_nak R 123 00 1 00 1
rd_after_nak R 040 00 0 FF 0
rand_0 X 000 00 0 00 0
rand_1 X 000 00 0 00 0
rand_2 X 000 00 0 00 0
rand_3 X 000 00 0 00 0
rand_4 X 000 00 0 00 0
rand_5 X 000 00 0 00 0
wr_busy B 0AA 5A 0 00 0
rd_busy R 0AA 00 0 5A 0

//--- sim/tb_eeprom.sv
`timescale 1ns/1ns
`include "eeprom_defs.svh"

module tb_eeprom;

    logic                    CLK;
    logic                    RESET;
    eeprom_pkg::eeprom_req_t req;
    logic                    req_valid;
    logic                    busy;
    logic                    done;
    eeprom_pkg::eeprom_rsp_t rsp;
    logic                    scl;
    logic                    sda_oe;
    logic                    sda_pd;
    wire                     sda;
    logic                    nak_mode;
    logic [7:0]              exp_data;
    logic                    exp_nack;
    logic [127:0]            test_name;
    int                      mon_errors;
    int                      tb_errors;
    int                      limit;
    logic                    loaded;
    logic [31:0]             lcg_state;

    logic [127:0] t_name [0:63];
    logic [7:0]   t_op   [0:63];
    logic [10:0]  t_addr [0:63];
    logic [7:0]   t_data [0:63];
    logic         t_nak  [0:63];
    logic [7:0]   t_exp  [0:63];
    logic         t_enk  [0:63];
    int           n_lines;
    int           n_reqs;

    assign sda = ~(sda_oe | sda_pd);  // open drain

    eeprom_ctrl_top u_eeprom_ctrl_top
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .req       (req),
        .req_valid (req_valid),
        .busy      (busy),
        .done      (done),
        .rsp       (rsp),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda_in    (sda)
    );

    eeprom_slave_model u_model
    (
        .scl      (scl),
        .sda      (sda),
        .nak_mode (nak_mode),
        .sda_pd   (sda_pd)
    );

    eeprom_monitor u_mon
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .busy      (busy),
        .done      (done),
        .rsp       (rsp),
        .exp_data  (exp_data),
        .exp_nack  (exp_nack),
        .test_name (test_name),
        .errors    (mon_errors)
    );

    initial
    begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return (s * 32'd1103515245 + 32'd12345) & 32'h7fff_ffff;
    endfunction

    task automatic load_trace();
        int           fd;
        int           cnt;
        string        line;
        logic [127:0] nm;
        logic [7:0]   oc;
        logic [31:0]  a;
        logic [31:0]  d;
        logic [31:0]  k;
        logic [31:0]  e;
        logic [31:0]  n;
        fd = $fopen("sim/eeprom_trace.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the trace file");
            tb_errors = tb_errors + 1;
            return;
        end
        while (!$feof(fd) && n_lines < 64)
        begin
            cnt = $fgets(line, fd);
            if (cnt > 1 && line.getc(0) != "#")
            begin
                cnt = $sscanf(line, "%s %s %h %h %h %h %h", nm, oc, a, d, k, e, n);
                if (cnt == 7)
                begin
                    t_name[n_lines] = nm;
                    t_op[n_lines]   = oc;
                    t_addr[n_lines] = a[10:0];
                    t_data[n_lines] = d[7:0];
                    t_nak[n_lines]  = k[0];
                    t_exp[n_lines]  = e[7:0];
                    t_enk[n_lines]  = n[0];
                    n_reqs  = n_reqs + ((oc == "X") ? 2 : 1);  // random is write plus read
                    n_lines = n_lines + 1;
                end
                else
                begin
                    $display("malformed trace line: %s", line);
                    tb_errors = tb_errors + 1;
                end
            end
        end
        $fclose(fd);
        if (n_lines == 0)
        begin
            $display("the trace file holds no requests");
            tb_errors = tb_errors + 1;
        end
    endtask

    task automatic run_request(input logic rd, input logic [10:0] addr, input logic [7:0] data,
                               input logic [7:0] ed, input logic en, input logic pulse);
        while (busy)
            @(negedge CLK);
        exp_data  = ed;
        exp_nack  = en;
        req.op    = rd ? eeprom_pkg::EE_READ : eeprom_pkg::EE_WRITE;
        req.addr  = addr;
        req.wdata = data;
        req_valid = 1'b1;
        @(negedge CLK);
        req_valid = 1'b0;
        if (pulse)
        begin
            repeat (10) @(negedge CLK);
            req.wdata = ~data;  // must be ignored
            req_valid = 1'b1;
            @(negedge CLK);
            req_valid = 1'b0;
        end
        while (!done)
            @(negedge CLK);
        @(negedge CLK);  // monitor sees done on the rising edge before this
    endtask

    task automatic finish_run();
        int chk_errors;
        int total;
        chk_errors = u_eeprom_ctrl_top.u_bit.u_chk.fail_cnt;
        total      = mon_errors + tb_errors + chk_errors;
        $display("errors: %0d (monitor %0d, testbench %0d, assertions %0d)",
                 total, mon_errors, tb_errors, chk_errors);
        if (total == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    endtask

    initial
    begin
        logic [10:0] ra;
        logic [7:0]  rdat;
        RESET     = 1'b1;
        req       = '0;
        req_valid = 1'b0;
        nak_mode  = 1'b0;
        exp_data  = '0;
        exp_nack  = 1'b0;
        test_name = "reset";
        tb_errors = 0;
        n_lines   = 0;
        n_reqs    = 0;
        loaded    = 1'b0;
        lcg_state = 32'd49;
        load_trace();
        limit  = n_reqs * (192 * `EE_QTR_CLKS + 20) + 8;
        loaded = 1'b1;
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        for (int i = 0; i < n_lines; i++)
        begin
            test_name = t_name[i];
            nak_mode  = t_nak[i];
            if (t_op[i] == "X")
            begin
                lcg_state = lcg_next(lcg_state);
                ra        = lcg_state[26:16];
                lcg_state = lcg_next(lcg_state);
                rdat      = lcg_state[23:16];
                run_request(1'b0, ra, rdat, 8'h00, 1'b0, 1'b0);
                run_request(1'b1, ra, 8'h00, rdat, 1'b0, 1'b0);
            end
            else if (t_op[i] == "B")
                run_request(1'b0, t_addr[i], t_data[i], t_exp[i], t_enk[i], 1'b1);
            else
                run_request(t_op[i] == "R", t_addr[i], t_data[i], t_exp[i], t_enk[i], 1'b0);
        end
        @(negedge CLK);
        finish_run();
    end

    initial
    begin
        wait (loaded);
        repeat (limit) @(posedge CLK);
        $display("timeout: no done within %0d cycles", limit);
        tb_errors = tb_errors + 1;
        finish_run();
    end

endmodule

//--- tb.f
+incdir+logic
logic/eeprom_pkg.sv
logic/i2c_bit_engine.sv
logic/eeprom_sequencer.sv
logic/eeprom_ctrl_top.sv
sim/eeprom_slave_model.sv
sim/eeprom_monitor.sv
sim/eeprom_checker.sv
sim/tb_eeprom.sv
